// ==== src/nocPkg.sv ====
package nocPkg;

  // Input channels of the output port.
  localparam int numPorts = 5;

  typedef logic [2:0] portIdx;

  localparam portIdx portL = 3'd0;
  localparam portIdx portN = 3'd1;
  localparam portIdx portE = 3'd2;
  localparam portIdx portW = 3'd3;
  localparam portIdx portS = 3'd4;

  typedef logic [2:0] flitKind;

  localparam flitKind kindHead = 3'b001;
  localparam flitKind kindBody = 3'b010;
  localparam flitKind kindTail = 3'b100;

  // The length sits in the low bits of a head flit and counts the head itself.
  localparam int lenW = 12;

  typedef struct packed {
    flitKind     kind;
    logic [31:0] data;
  } flitT;

endpackage

// ==== src/regPkg.sv ====
package regPkg;

  localparam int cntW = 16;

  // Port enable mask, one bit per input port.
  localparam logic [7:0] addrCtrl = 8'h00;

  // Packet counters for L, N, E, W and S follow every four bytes.
  localparam logic [7:0] addrCnt0 = 8'h04;

  localparam logic [4:0] ctrlReset = 5'b11111; // All ports enabled.

endpackage

// ==== src/flitIf.sv ====
`timescale 1ns/100ps

interface flitIf;
  import nocPkg::*;

  logic valid;
  logic ready;
  flitT flit;
  logic head; // Front flit is a head flit.

  modport tx (
    output valid,
    output flit,
    output head,
    input  ready
  );

  modport rx (
    input  valid,
    input  flit,
    input  head,
    output ready
  );

endinterface

// ==== src/flitBuffer.sv ====
`timescale 1ns/100ps

module flitBuffer #(
  parameter int bufDepth = 4
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         inValid,
  output logic         inReady,
  input  nocPkg::flitT inFlit,
  flitIf.tx            out
);
  import nocPkg::*;

  localparam int ptrW = $clog2(bufDepth);

  flitT            mem [bufDepth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0]   fill;
  logic            wrEn;
  logic            rdEn;

  assign inReady   = (fill != (ptrW + 1)'(bufDepth));
  assign wrEn      = inValid && inReady;
  assign rdEn      = out.valid && out.ready;
  assign out.valid = (fill != '0);
  assign out.flit  = mem[rdPtr];
  assign out.head  = out.valid && (mem[rdPtr].kind == kindHead);

  always_ff @(posedge clk)
  begin
    if (wrEn)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill  <= '0;
    end
    else
    begin
      if (wrEn)
        wrPtr <= wrPtr + 1'b1; // Wraps since the depth is a power of two.
      if (rdEn)
        rdPtr <= rdPtr + 1'b1;
      if (wrEn && !rdEn)
        fill <= fill + 1'b1;
      else if (rdEn && !wrEn)
        fill <= fill - 1'b1;
    end
  end

  // A write into a full buffer would land on the waiting front flit.
  assert property (@(posedge clk) disable iff (rst)
    out.valid && !out.ready |=> $stable(out.flit));

endmodule

// ==== src/packetCounter.sv ====
`timescale 1ns/100ps

module packetCounter (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    load,
  input  logic [nocPkg::lenW-1:0] length,
  input  logic                    step,
  output logic                    last
);
  import nocPkg::*;

  logic            active;
  logic [lenW-1:0] target;
  logic [lenW-1:0] count;

  always_comb
  begin
    if (load)
      last = (length <= lenW'(1)); // Single-flit packet.
    else
      last = active && (count + lenW'(1) == target);
  end

  always_ff @(posedge clk)
  begin
    if (load)
      target <= length;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      active <= 1'b0;
      count  <= '0;
    end
    else if (load)
    begin
      active <= (length > lenW'(1));
      count  <= lenW'(1); // The head counts as the first flit.
    end
    else if (step)
    begin
      if (last)
        active <= 1'b0;
      count <= count + 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (rst) step |-> active);

endmodule

// ==== src/outputArbiter.sv ====
`timescale 1ns/100ps

module outputArbiter (
  input  logic                          clk,
  input  logic                          rst,
  flitIf.rx                             in [nocPkg::numPorts],
  input  logic [nocPkg::numPorts-1:0]   enMask,
  output logic                          outValid,
  input  logic                          outReady,
  output nocPkg::flitT                  outFlit,
  output logic                          headSent,
  output nocPkg::portIdx                headPort
);
  import nocPkg::*;

  localparam logic [numPorts:0] stIdle = 1;

  logic [numPorts:0]   state;
  logic [numPorts:0]   stateNext;
  logic [numPorts-1:0] vld;
  logic [numPorts-1:0] heads;
  logic [numPorts-1:0] eligible;
  logic [numPorts-1:0] pick;
  logic [numPorts-1:0] sel;
  logic [numPorts-1:0] load;
  logic [numPorts-1:0] step;
  logic [numPorts-1:0] last;
  flitT                flits [numPorts];
  flitT                selFlit;
  portIdx              selPort;
  portIdx              lastPort;
  logic                slotFree;
  logic                xfer;
  logic                lastSel;

  assign slotFree = !outValid || outReady; // Output register empty or draining.

  for (genvar i = 0; i < numPorts; i++)
  begin : gPort
    assign vld[i]      = in[i].valid;
    assign heads[i]    = in[i].head;
    assign flits[i]    = in[i].flit;
    assign in[i].ready = sel[i] && slotFree;
    assign load[i]     = sel[i] && vld[i] && slotFree && heads[i];
    assign step[i]     = sel[i] && vld[i] && slotFree && !heads[i];

    packetCounter uCnt (
      .clk    (clk),
      .rst    (rst),
      .load   (load[i]),
      .length (flits[i].data[lenW-1:0]),
      .step   (step[i]),
      .last   (last[i])
    );
  end

  assign eligible = enMask & vld & heads;

  // Search from the port after the last grant.
  always_comb
  begin
    int idx;
    pick = '0;
    for (int k = numPorts; k >= 1; k--)
    begin
      idx = int'(lastPort) + k;
      if (idx >= numPorts)
        idx = idx - numPorts;
      if (eligible[idx])
      begin
        pick      = '0;
        pick[idx] = 1'b1;
      end
    end
  end

  assign sel     = state[0] ? pick : state[numPorts:1];
  assign xfer    = |(sel & vld) && slotFree;
  assign lastSel = |(sel & last);

  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (sel[i])
        selFlit = flits[i];
    end
  end

  always_comb
  begin
    case (sel)
      5'b00001: selPort = portL;
      5'b00010: selPort = portN;
      5'b00100: selPort = portE;
      5'b01000: selPort = portW;
      5'b10000: selPort = portS;
      default:  selPort = portL;
    endcase
  end

  always_comb
  begin
    if (xfer && lastSel)
      stateNext = stIdle; // Packet done, release the lock.
    else if (|sel)
      stateNext = {sel, 1'b0};
    else
      stateNext = stIdle;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= stIdle;
      lastPort <= portS; // First search after reset begins at L.
      outValid <= 1'b0;
    end
    else
    begin
      state <= stateNext;
      if (state[0] && |pick)
        lastPort <= selPort;
      if (xfer)
        outValid <= 1'b1;
      else if (outReady)
        outValid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (xfer)
      outFlit <= selFlit;
  end

  assign headSent = |load;
  assign headPort = selPort;

  assert property (@(posedge clk) disable iff (rst) $onehot(state));

  // The counter's notion of the final flit agrees with the flit kinds.
  assert property (@(posedge clk) disable iff (rst)
    xfer && lastSel |-> (selFlit.kind == kindTail) || (selFlit.kind == kindHead));

endmodule

// ==== src/apbRegs.sv ====
`timescale 1ns/100ps

module apbRegs (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [7:0]                  paddr,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [31:0]                 pwdata,
  output logic [31:0]                 prdata,
  output logic                        pready,
  output logic                        pslverr,
  output logic [nocPkg::numPorts-1:0] enMask,
  input  logic                        headSent,
  input  nocPkg::portIdx              headPort
);
  import nocPkg::*;
  import regPkg::*;

  logic [numPorts-1:0] ctrl;
  logic [cntW-1:0]     cnt [numPorts];
  logic [7:0]          off;
  portIdx              cntIdx;
  logic                access;
  logic                isCtrl;
  logic                cntHit;

  assign access = psel && penable;
  assign off    = paddr - addrCnt0; // Addresses below the counters wrap out of range.
  assign cntIdx = off[4:2];
  assign isCtrl = (paddr == addrCtrl);
  assign cntHit = (off[1:0] == 2'b00) && (off[7:2] < numPorts);

  assign pready  = 1'b1; // No wait states.
  assign pslverr = access && (!(isCtrl || cntHit) || (pwrite && cntHit));
  assign enMask  = ctrl;

  always_comb
  begin
    prdata = '0;
    if (isCtrl)
      prdata[numPorts-1:0] = ctrl;
    else if (cntHit)
      prdata[cntW-1:0] = cnt[cntIdx];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ctrl <= ctrlReset;
      for (int i = 0; i < numPorts; i++)
        cnt[i] <= '0;
    end
    else
    begin
      if (access && pwrite && isCtrl)
        ctrl <= pwdata[numPorts-1:0];
      for (int i = 0; i < numPorts; i++)
      begin
        // Counters stop at full scale.
        if (headSent && (headPort == portIdx'(i)) && (cnt[i] != '1))
          cnt[i] <= cnt[i] + 1'b1;
      end
    end
  end

endmodule

// ==== src/routerOutput.sv ====
`timescale 1ns/100ps

module routerOutput #(
  parameter int bufDepth = 4
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic [nocPkg::numPorts-1:0]               inValid,
  output logic [nocPkg::numPorts-1:0]               inReady,
  input  nocPkg::flitT [nocPkg::numPorts-1:0]       inFlit,
  output logic                                      outValid,
  input  logic                                      outReady,
  output nocPkg::flitT                              outFlit,
  input  logic [7:0]                                paddr,
  input  logic                                      psel,
  input  logic                                      penable,
  input  logic                                      pwrite,
  input  logic [31:0]                               pwdata,
  output logic [31:0]                               prdata,
  output logic                                      pready,
  output logic                                      pslverr
);
  import nocPkg::*;

  logic [numPorts-1:0] enMask;
  logic                headSent;
  portIdx              headPort;

  flitIf chan [numPorts] ();

  for (genvar i = 0; i < numPorts; i++)
  begin : gBuf
    flitBuffer #(
      .bufDepth (bufDepth)
    ) uBuf (
      .clk     (clk),
      .rst     (rst),
      .inValid (inValid[i]),
      .inReady (inReady[i]),
      .inFlit  (inFlit[i]),
      .out     (chan[i])
    );
  end

  outputArbiter uArb (
    .clk      (clk),
    .rst      (rst),
    .in       (chan),
    .enMask   (enMask),
    .outValid (outValid),
    .outReady (outReady),
    .outFlit  (outFlit),
    .headSent (headSent),
    .headPort (headPort)
  );

  apbRegs uRegs (
    .clk      (clk),
    .rst      (rst),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .enMask   (enMask),
    .headSent (headSent),
    .headPort (headPort)
  );

endmodule

// ==== sim/tbRouterOutput.sv ====
`timescale 1ns/100ps

module tbRouterOutput;
  import nocPkg::*;
  import regPkg::*;

  localparam int bufDepth = 4;

  logic                clk = 1'b0;
  logic                rst = 1'b1;
  logic [numPorts-1:0] inValid = '0;
  logic [numPorts-1:0] inReady;
  flitT [numPorts-1:0] inFlit = '0;
  logic                outValid;
  logic                outReady = 1'b1;
  flitT                outFlit;
  logic [7:0]          paddr = '0;
  logic                psel = 1'b0;
  logic                penable = 1'b0;
  logic                pwrite = 1'b0;
  logic [31:0]         pwdata = '0;
  logic [31:0]         prdata;
  logic                pready;
  logic                pslverr;

  flitT                txQ [numPorts][$]; // Flits still to be driven per port.
  flitT                expQ [numPorts][$]; // Flits sent and not yet seen at the output.
  portIdx              pktOrder [$];
  int                  pktCount [numPorts] = '{default: 0};
  int                  acceptCnt [numPorts] = '{default: 0};
  logic [numPorts-1:0] fire = '0;
  int                  readyMode = 0; // 0 ready, 1 stalled, 2 random.
  portIdx              lockPort = portL;
  int                  remaining = 0;
  logic [31:0]         lcgState = 32'd34;
  logic [31:0]         rdyRnd;
  string               curTest = "reset";

  routerOutput #(
    .bufDepth (bufDepth)
  ) uut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .inFlit   (inFlit),
    .outValid (outValid),
    .outReady (outReady),
    .outFlit  (outFlit),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  task automatic abortRun();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic checkEq(input string what, input logic [63:0] expV, input logic [63:0] actV);
    if (expV !== actV)
    begin
      $display("ERR %s %s: expected %0h, actual %0h", curTest, what, expV, actV);
      abortRun();
    end
  endtask

  // Head data holds a random tag, the source port in 14:12 and the length in 11:0.
  task automatic sendPacket(input portIdx port, input int len);
    flitT        f;
    logic [31:0] r;
    r = lcgNext();
    f.kind = kindHead;
    f.data = {r[31:16], 1'b0, port, 12'(len)};
    txQ[port].push_back(f);
    expQ[port].push_back(f);
    for (int i = 1; i < len; i++)
    begin
      f.kind = (i == len - 1) ? kindTail : kindBody;
      f.data = lcgNext();
      txQ[port].push_back(f);
      expQ[port].push_back(f);
    end
  endtask

  // Inputs and outReady change 1 ns after the edge.
  always @(posedge clk)
  begin
    #1;
    for (int p = 0; p < numPorts; p++)
    begin
      if (fire[p])
      begin
        void'(txQ[p].pop_front());
        acceptCnt[p]++;
      end
      inValid[p] = (txQ[p].size() != 0);
      inFlit[p]  = (txQ[p].size() != 0) ? txQ[p][0] : '0;
    end
    if (readyMode == 2)
    begin
      rdyRnd   = lcgNext();
      outReady = rdyRnd[16];
    end
    else
      outReady = (readyMode == 0);
  end

  task automatic takeOutput(input flitT f);
    flitT expF;
    if (f.kind == kindHead)
    begin
      if (remaining != 0)
      begin
        $display("%s: a head flit broke into an open packet", curTest);
        abortRun();
      end
      lockPort  = f.data[14:12];
      remaining = int'(f.data[11:0]) - 1;
      pktOrder.push_back(lockPort);
      pktCount[lockPort]++;
    end
    else if (remaining == 0)
    begin
      $display("%s: a flit left the output outside of any packet", curTest);
      abortRun();
    end
    else
      remaining--;
    if (expQ[lockPort].size() == 0)
    begin
      $display("%s: output flit %h was never sent by port %0d", curTest, f, lockPort);
      abortRun();
    end
    expF = expQ[lockPort].pop_front();
    checkEq("output flit", 64'(expF), 64'(f));
  endtask

  // Values at the falling edge are the ones the next rising edge samples.
  always @(negedge clk)
  begin
    fire <= inValid & inReady;
    if (!rst && outValid && outReady)
      takeOutput(outFlit);
  end

  function automatic bit allEmpty();
    for (int p = 0; p < numPorts; p++)
    begin
      if (txQ[p].size() != 0 || expQ[p].size() != 0)
        return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic waitDrain(input int limit);
    int cycles;
    cycles = 0;
    while (!allEmpty() || outValid)
    begin
      if (cycles == limit)
      begin
        $display("%s: packets did not drain within %0d cycles", curTest, limit);
        abortRun();
      end
      cycles++;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic waitPortEmpty(input portIdx port, input int limit);
    int cycles;
    cycles = 0;
    while (expQ[port].size() != 0)
    begin
      if (cycles == limit)
      begin
        $display("%s: port %0d did not drain within %0d cycles", curTest, port, limit);
        abortRun();
      end
      cycles++;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic apbAccess(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
    int cycles;
    @(posedge clk);
    #1;
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    cycles  = 0;
    @(negedge clk);
    while (!pready)
    begin
      if (cycles == 20)
      begin
        $display("%s: APB access to %h never completed", curTest, addr);
        abortRun();
      end
      cycles++;
      @(negedge clk);
    end
    checkEq("pready wait states", 64'(0), 64'(cycles));
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic checkCounters();
    logic [31:0] rdata;
    logic        err;
    for (int p = 0; p < numPorts; p++)
    begin
      apbAccess(8'(addrCnt0 + 8'(4 * p)), 1'b0, '0, rdata, err);
      checkEq("counter pslverr", 64'(0), 64'(err));
      checkEq("packet counter", 64'(pktCount[p]), 64'(rdata));
    end
  endtask

  task automatic testReset();
    logic [31:0] rdata;
    logic        err;
    curTest = "reset";
    checkEq("inReady", 64'(5'b11111), 64'(inReady));
    checkEq("outValid", 64'(0), 64'(outValid));
    apbAccess(addrCtrl, 1'b0, '0, rdata, err);
    checkEq("enable mask", 64'(5'b11111), 64'(rdata)); // Every port enabled.
    checkCounters();
  endtask

  task automatic testWormhole();
    curTest = "wormhole";
    pktOrder.delete();
    for (int p = 0; p < numPorts; p++)
      sendPacket(portIdx'(p), 3 + p);
    waitDrain(1000);
    checkEq("packets", 64'(numPorts), 64'(pktOrder.size()));
    for (int i = 0; i < numPorts; i++)
      checkEq("grant order", 64'(i), 64'(pktOrder[i])); // Round robin from L.
  endtask

  task automatic testFairness();
    portIdx expOrder [4] = '{portL, portW, portL, portW};
    curTest = "fairness";
    pktOrder.delete();
    sendPacket(portL, 3);
    sendPacket(portL, 2);
    sendPacket(portW, 4);
    sendPacket(portW, 3);
    waitDrain(1000);
    checkEq("packets", 64'(4), 64'(pktOrder.size()));
    for (int i = 0; i < 4; i++)
      checkEq("grant order", 64'(expOrder[i]), 64'(pktOrder[i]));
  endtask

  task automatic testSinglePacket();
    curTest = "single";
    pktOrder.delete();
    sendPacket(portE, 4);
    waitDrain(500);
    checkEq("packets", 64'(1), 64'(pktOrder.size()));
    checkEq("source port", 64'(portE), 64'(pktOrder[0]));
  endtask

  task automatic testBackPressure();
    int base;
    int cycles;
    curTest   = "backpressure";
    readyMode = 1;
    base      = acceptCnt[portN];
    sendPacket(portN, 8);
    cycles = 0;
    @(negedge clk);
    while (inReady[portN])
    begin
      if (cycles == 100)
      begin
        $display("%s: inReady never dropped on a stalled port", curTest);
        abortRun();
      end
      cycles++;
      @(negedge clk);
    end
    // One flit waits in the output register and the rest fill the buffer.
    checkEq("accepted flits", 64'(bufDepth + 1), 64'(acceptCnt[portN] - base));
    sendPacket(portE, 5);
    sendPacket(portS, 2);
    sendPacket(portL, 6);
    readyMode = 2;
    waitDrain(3000);
    readyMode = 0;
  endtask

  task automatic testMask();
    logic [31:0] rdata;
    logic        err;
    int          sCountBase;
    curTest = "mask";
    apbAccess(addrCtrl, 1'b1, 32'h0f, rdata, err);
    checkEq("mask write pslverr", 64'(0), 64'(err));
    sCountBase = pktCount[portS];
    pktOrder.delete();
    sendPacket(portS, 3);
    sendPacket(portL, 2);
    waitPortEmpty(portL, 500);
    repeat (40) @(posedge clk);
    #1;
    checkEq("held flits", 64'(3), 64'(expQ[portS].size()));
    checkEq("masked packets", 64'(sCountBase), 64'(pktCount[portS]));
    apbAccess(addrCtrl, 1'b1, 32'h1f, rdata, err);
    waitDrain(500);
    checkEq("released port", 64'(portS), 64'(pktOrder[pktOrder.size() - 1]));
  endtask

  task automatic testApb();
    logic [31:0] rdata;
    logic        err;
    curTest = "apb";
    checkCounters();
    apbAccess(8'h40, 1'b0, '0, rdata, err);
    checkEq("unmapped read pslverr", 64'(1), 64'(err));
    apbAccess(addrCnt0, 1'b1, 32'h1234, rdata, err);
    checkEq("counter write pslverr", 64'(1), 64'(err));
    checkCounters(); // A rejected write must leave the counters alone.
  endtask

  initial
  begin
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    testReset();
    testWormhole();
    testFairness();
    testSinglePacket();
    testBackPressure();
    testMask();
    testApb();
    $display("Test OK");
    $finish;
  end

endmodule

// ==== project.f ====
src/nocPkg.sv
src/regPkg.sv
src/flitIf.sv
src/flitBuffer.sv
src/packetCounter.sv
src/outputArbiter.sv
src/apbRegs.sv
src/routerOutput.sv
sim/tbRouterOutput.sv

// ==== run.sh ====
#!/bin/bash
# Builds the testbench with Verilator, runs it and looks for the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module tbRouterOutput \
  --Mdir obj_dir -o simv &&
  ./obj_dir/simv | tee /dev/stderr | grep -q "Test OK" &&
  echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
